/* hdl/glay_setup_defs.svh */
// --------------------
// Widths, FIFO sizing, setup timing and
// APB register map of the setup stage
// --------------------

`ifndef GLAY_SETUP_DEFS_SVH
`define GLAY_SETUP_DEFS_SVH

// Datapath widths
`define GLAY_ADDR_W 32
`define GLAY_DATA_W 32
`define GLAY_TAG_W 8
`define GLAY_COUNT_W 16

// Address step between consecutive line requests
`define GLAY_LINE_BYTES 64

// FIFO sizing and post-reset busy window
`define GLAY_FIFO_DEPTH 8
`define GLAY_FIFO_SETUP_CYCLES 6

// APB register offsets
`define GLAY_REG_BASE 8'h00
`define GLAY_REG_LINES 8'h04
`define GLAY_REG_CTRL 8'h08
`define GLAY_REG_STATUS 8'h0C
`define GLAY_REG_SUM 8'h10

`endif

/* hdl/glay_setup_pkg.sv */
// --------------------
// Shared types of the setup stage:
// FSM states, memory request and response beats
// --------------------

`include "glay_setup_defs.svh"

package glay_setup_pkg;

    // --------------------
    // Setup FSM
    // --------------------
    typedef enum logic [2:0] {
        SETUP_RESET,
        SETUP_IDLE,
        SETUP_REQ_START,
        SETUP_REQ_BUSY,
        SETUP_REQ_DONE
    } setup_state_t;

    // --------------------
    // Memory port beats
    // --------------------
    // One cache-line read
    typedef struct packed {
        logic [`GLAY_ADDR_W-1:0] addr;
        logic [`GLAY_TAG_W-1:0]  tag;
    } mem_req_t;

    // Read data coming back, in request order
    typedef struct packed {
        logic [`GLAY_TAG_W-1:0]  tag;
        logic [`GLAY_DATA_W-1:0] data;
    } mem_resp_t;

endpackage

/* hdl/glay_sync_fifo.sv */
// --------------------
// Synchronous FIFO, payload type set per instance
// Holds off traffic for a few cycles after reset
// --------------------

`timescale 1ns/1ns
`include "glay_setup_defs.svh"

module glay_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `GLAY_FIFO_DEPTH
) (
    input  logic     ap_clk,
    input  logic     setup_areset,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     full,
    output logic     empty,
    output logic     setup_busy
);

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int SETUP_W = $clog2(`GLAY_FIFO_SETUP_CYCLES + 1);

    payload_t             mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic [SETUP_W-1:0]   setup_cnt;
    logic                 do_wr;
    logic                 do_rd;

    // --------------------
    // Post-reset busy window
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            setup_cnt <= SETUP_W'(`GLAY_FIFO_SETUP_CYCLES);
        end else if (setup_cnt != '0) begin
            setup_cnt <= setup_cnt - 1'b1;
        end
    end

    assign setup_busy = (setup_cnt != '0);

    // Looks full and empty while busy, so both sides hold off
    assign full  = (count == CNT_W'(DEPTH)) | setup_busy;
    assign empty = (count == '0) | setup_busy;

    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head entry, first-word fall-through
    assign dout = mem[rd_ptr];

endmodule

/* hdl/glay_serial_read_engine.sv */
// --------------------
// Serial read engine
// Ordered cache-line requests from base and count
// --------------------

`timescale 1ns/1ns
`include "glay_setup_defs.svh"

module glay_serial_read_engine (
    input  logic                     ap_clk,
    input  logic                     setup_areset,
    input  logic                     cfg_start,
    input  logic [`GLAY_ADDR_W-1:0]  cfg_base,
    input  logic [`GLAY_COUNT_W-1:0] cfg_lines,
    output logic                     req_wr_en,
    output glay_setup_pkg::mem_req_t req_data,
    input  logic                     req_full,
    output logic                     issue_done
);

    logic [`GLAY_ADDR_W-1:0]  next_addr;
    logic [`GLAY_TAG_W-1:0]   next_tag;
    logic [`GLAY_COUNT_W-1:0] remaining;

    // --------------------
    // Line counter
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            remaining <= '0;
        end else if (cfg_start) begin
            remaining <= cfg_lines;
        end else if (req_wr_en) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Address and tag of the next request
    always_ff @(posedge ap_clk) begin
        if (cfg_start) begin
            next_addr <= cfg_base;
            next_tag  <= '0;
        end else if (req_wr_en) begin
            // Step one cache line, tag wraps at 256
            next_addr <= next_addr + `GLAY_ADDR_W'(`GLAY_LINE_BYTES);
            next_tag  <= next_tag + 1'b1;
        end
    end

    // --------------------
    // Request output
    // --------------------
    // At most one write per cycle, stalls on a full FIFO
    assign req_wr_en     = (remaining != '0) & ~req_full;
    assign req_data.addr = next_addr;
    assign req_data.tag  = next_tag;

    // Zero lines is done straight after the load
    assign issue_done = (remaining == '0);

endmodule

/* hdl/glay_kernel_setup.sv */
// --------------------
// Kernel setup FSM with its read engine
// Response FIFO, response count and checksum
// --------------------

`timescale 1ns/1ns
`include "glay_setup_defs.svh"

module glay_kernel_setup (
    input  logic                     ap_clk,
    input  logic                     setup_areset,
    input  logic                     desc_valid,
    input  logic [`GLAY_ADDR_W-1:0]  desc_base,
    input  logic [`GLAY_COUNT_W-1:0] desc_lines,
    input  logic                     fifo_busy,
    output logic                     req_wr_en,
    output glay_setup_pkg::mem_req_t req_data,
    input  logic                     req_full,
    input  logic                     mem_resp_valid,
    input  logic [`GLAY_TAG_W-1:0]   mem_resp_tag,
    input  logic [`GLAY_DATA_W-1:0]  mem_resp_data,
    output logic                     mem_resp_ready,
    output logic                     resp_fifo_busy,
    output logic                     busy,
    output logic                     done,
    output logic [`GLAY_COUNT_W-1:0] resp_count,
    output logic [`GLAY_DATA_W-1:0]  checksum
);

    glay_setup_pkg::setup_state_t state;
    glay_setup_pkg::setup_state_t next_state;
    glay_setup_pkg::mem_resp_t    resp_din;
    glay_setup_pkg::mem_resp_t    resp_dout;

    logic [`GLAY_ADDR_W-1:0]  base_reg;
    logic [`GLAY_COUNT_W-1:0] lines_reg;
    logic [`GLAY_COUNT_W-1:0] count_nxt;
    logic                     engine_start;
    logic                     issue_done;
    logic                     resp_full;
    logic                     resp_empty;
    logic                     pop;
    logic                     accept;
    logic                     finish;

    // Descriptor taken only from IDLE
    assign accept = (state == glay_setup_pkg::SETUP_IDLE) & desc_valid;

    // Count including this cycle's pop, so done lands the cycle after the last pop
    assign count_nxt = resp_count + `GLAY_COUNT_W'(pop);
    // Start pulse blocks a stale issue_done from the previous run
    assign finish    = (state == glay_setup_pkg::SETUP_REQ_BUSY) & ~engine_start &
                       issue_done & (count_nxt == lines_reg);

    // --------------------
    // Setup FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            state <= glay_setup_pkg::SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // Hold until both FIFOs are out of setup
            glay_setup_pkg::SETUP_RESET:     if (!fifo_busy) next_state = glay_setup_pkg::SETUP_IDLE;
            glay_setup_pkg::SETUP_IDLE:      if (desc_valid) next_state = glay_setup_pkg::SETUP_REQ_START;
            glay_setup_pkg::SETUP_REQ_START: next_state = glay_setup_pkg::SETUP_REQ_BUSY;
            glay_setup_pkg::SETUP_REQ_BUSY:  if (finish) next_state = glay_setup_pkg::SETUP_REQ_DONE;
            glay_setup_pkg::SETUP_REQ_DONE:  next_state = glay_setup_pkg::SETUP_IDLE;
            default:                         next_state = glay_setup_pkg::SETUP_RESET;
        endcase
    end

    // Status flags and engine start, registered off the state
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            engine_start <= 1'b0;
            busy         <= 1'b0;
            done         <= 1'b0;
        end else begin
            engine_start <= (state == glay_setup_pkg::SETUP_REQ_START);
            if (accept) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (finish) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Latched descriptor
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            base_reg  <= desc_base;
            lines_reg <= desc_lines;
        end
    end

    // --------------------
    // Request generation
    // --------------------
    glay_serial_read_engine u_serial_read_engine (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .cfg_start    (engine_start),
        .cfg_base     (base_reg),
        .cfg_lines    (lines_reg),
        .req_wr_en    (req_wr_en),
        .req_data     (req_data),
        .req_full     (req_full),
        .issue_done   (issue_done)
    );

    // --------------------
    // Response path
    // --------------------
    assign resp_din.tag   = mem_resp_tag;
    assign resp_din.data  = mem_resp_data;
    assign mem_resp_ready = ~resp_full;
    // Drain one beat per cycle
    assign pop            = ~resp_empty;

    glay_sync_fifo #(
        .payload_t (glay_setup_pkg::mem_resp_t),
        .DEPTH     (`GLAY_FIFO_DEPTH)
    ) u_resp_fifo (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (mem_resp_valid),
        .din          (resp_din),
        .rd_en        (pop),
        .dout         (resp_dout),
        .full         (resp_full),
        .empty        (resp_empty),
        .setup_busy   (resp_fifo_busy)
    );

    // Count and wrapping checksum, cleared by a new start
    always_ff @(posedge ap_clk) begin
        if (setup_areset || accept) begin
            resp_count <= '0;
            checksum   <= '0;
        end else if (pop) begin
            resp_count <= count_nxt;
            checksum   <= checksum + resp_dout.data;
        end
    end

endmodule

/* hdl/glay_apb_descriptor.sv */
// --------------------
// APB slave for the graph descriptor
// Base and line registers, start command, status readback
// --------------------

`timescale 1ns/1ns
`include "glay_setup_defs.svh"

module glay_apb_descriptor (
    input  logic                     ap_clk,
    input  logic                     setup_areset,
    input  logic [7:0]               paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     busy,
    input  logic                     done,
    input  logic                     fifo_setup,
    input  logic [`GLAY_COUNT_W-1:0] resp_count,
    input  logic [`GLAY_DATA_W-1:0]  checksum,
    output logic                     desc_valid,
    output logic [`GLAY_ADDR_W-1:0]  desc_base,
    output logic [`GLAY_COUNT_W-1:0] desc_lines
);

    logic access;
    logic wr_access;
    logic mapped;
    logic start_req;
    logic start_refused;

    // Zero wait states, every transfer ends in its access phase
    assign pready    = 1'b1;
    assign access    = psel & penable;
    assign wr_access = access & pwrite;

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        case (paddr)
            `GLAY_REG_BASE,
            `GLAY_REG_LINES,
            `GLAY_REG_CTRL,
            `GLAY_REG_STATUS,
            `GLAY_REG_SUM: mapped = 1'b1;
            default:       mapped = 1'b0;
        endcase
    end

    // Start bit written to CTRL
    assign start_req     = wr_access & (paddr == `GLAY_REG_CTRL) & pwdata[0];
    // Kernel still running or FIFOs not out of setup
    assign start_refused = start_req & (busy | fifo_setup);

    assign pslverr = access & (~mapped | start_refused);

    // --------------------
    // Descriptor registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_base  <= '0;
            desc_lines <= '0;
            desc_valid <= 1'b0;
        end else begin
            // One-cycle start pulse after the access phase
            desc_valid <= start_req & ~start_refused;
            if (wr_access && paddr == `GLAY_REG_BASE) begin
                desc_base <= pwdata[`GLAY_ADDR_W-1:0];
            end
            if (wr_access && paddr == `GLAY_REG_LINES) begin
                desc_lines <= pwdata[`GLAY_COUNT_W-1:0];
            end
        end
    end

    // Read mux, status packs busy, done and the response count
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `GLAY_REG_BASE:   prdata = desc_base;
                `GLAY_REG_LINES:  prdata = {{(32-`GLAY_COUNT_W){1'b0}}, desc_lines};
                `GLAY_REG_STATUS: prdata = {resp_count, 14'b0, done, busy};
                `GLAY_REG_SUM:    prdata = checksum;
                default:          prdata = '0;
            endcase
        end
    end

endmodule

/* hdl/glay_setup_top.sv */
// --------------------
// Setup stage top level
// APB descriptor, kernel setup, request FIFO
// --------------------

`timescale 1ns/1ns
`include "glay_setup_defs.svh"

module glay_setup_top (
    input  logic                    ap_clk,
    input  logic                    setup_areset,
    input  logic [7:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output logic [`GLAY_ADDR_W-1:0] mem_req_addr,
    output logic [`GLAY_TAG_W-1:0]  mem_req_tag,
    input  logic                    mem_resp_valid,
    output logic                    mem_resp_ready,
    input  logic [`GLAY_TAG_W-1:0]  mem_resp_tag,
    input  logic [`GLAY_DATA_W-1:0] mem_resp_data,
    output logic                    fifo_setup,
    output logic                    done
);

    logic                     desc_valid;
    logic [`GLAY_ADDR_W-1:0]  desc_base;
    logic [`GLAY_COUNT_W-1:0] desc_lines;
    logic                     busy;
    logic [`GLAY_COUNT_W-1:0] resp_count;
    logic [`GLAY_DATA_W-1:0]  checksum;
    logic                     req_wr_en;
    logic                     req_full;
    logic                     req_empty;
    logic                     req_fifo_busy;
    logic                     resp_fifo_busy;
    glay_setup_pkg::mem_req_t req_data;
    glay_setup_pkg::mem_req_t req_head;

    // Busy while either FIFO is still in its setup window
    assign fifo_setup = req_fifo_busy | resp_fifo_busy;

    glay_apb_descriptor u_apb_descriptor (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .busy         (busy),
        .done         (done),
        .fifo_setup   (fifo_setup),
        .resp_count   (resp_count),
        .checksum     (checksum),
        .desc_valid   (desc_valid),
        .desc_base    (desc_base),
        .desc_lines   (desc_lines)
    );

    glay_kernel_setup u_kernel_setup (
        .ap_clk         (ap_clk),
        .setup_areset   (setup_areset),
        .desc_valid     (desc_valid),
        .desc_base      (desc_base),
        .desc_lines     (desc_lines),
        .fifo_busy      (fifo_setup),
        .req_wr_en      (req_wr_en),
        .req_data       (req_data),
        .req_full       (req_full),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_tag   (mem_resp_tag),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_ready (mem_resp_ready),
        .resp_fifo_busy (resp_fifo_busy),
        .busy           (busy),
        .done           (done),
        .resp_count     (resp_count),
        .checksum       (checksum)
    );

    // --------------------
    // Memory request port
    // --------------------
    glay_sync_fifo #(
        .payload_t (glay_setup_pkg::mem_req_t),
        .DEPTH     (`GLAY_FIFO_DEPTH)
    ) u_req_fifo (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (req_wr_en),
        .din          (req_data),
        .rd_en        (mem_req_ready),
        .dout         (req_head),
        .full         (req_full),
        .empty        (req_empty),
        .setup_busy   (req_fifo_busy)
    );

    // Head entry stays put until the memory side takes it
    assign mem_req_valid = ~req_empty;
    assign mem_req_addr  = req_head.addr;
    assign mem_req_tag   = req_head.tag;

endmodule

/* sim/glay_setup_asserts.sv */
// --------------------
// Concurrent checks on the setup top ports
// --------------------

`timescale 1ns/1ns
`include "glay_setup_defs.svh"

module glay_setup_asserts (
    input logic                    ap_clk,
    input logic                    setup_areset,
    input logic                    pready,
    input logic                    fifo_setup,
    input logic                    done,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input logic [`GLAY_ADDR_W-1:0] mem_req_addr,
    input logic [`GLAY_TAG_W-1:0]  mem_req_tag
);

    // Head request held while the memory side stalls
    req_stable_a: assert property (@(posedge ap_clk) disable iff (setup_areset)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_tag))
        else $error("memory request changed while stalled");

    // Zero wait state slave
    pready_high_a: assert property (@(posedge ap_clk) pready)
        else $error("pready went low");

    // No traffic during the FIFO setup window
    setup_quiet_a: assert property (@(posedge ap_clk) disable iff (setup_areset)
        fifo_setup |-> !mem_req_valid)
        else $error("request valid while FIFOs in setup");

    // All requests gone before completion
    done_after_reqs_a: assert property (@(posedge ap_clk) disable iff (setup_areset)
        $rose(done) |-> !mem_req_valid)
        else $error("done rose with a request still pending");

endmodule

bind glay_setup_top glay_setup_asserts u_setup_asserts (
    .ap_clk        (ap_clk),
    .setup_areset  (setup_areset),
    .pready        (pready),
    .fifo_setup    (fifo_setup),
    .done          (done),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_addr  (mem_req_addr),
    .mem_req_tag   (mem_req_tag)
);

/* sim/glay_setup_tb.sv */
// --------------------
// Setup stage testbench
// APB host, memory responder, watchdog,
// descriptor tests read from the stim file
// --------------------

`timescale 1ns/1ns
`include "glay_setup_defs.svh"

module glay_setup_tb;

    localparam int NUM_TESTS = 6;

    logic                    ap_clk = 1'b0;
    logic                    setup_areset;
    logic [7:0]              paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    mem_req_valid;
    logic                    mem_req_ready;
    logic [`GLAY_ADDR_W-1:0] mem_req_addr;
    logic [`GLAY_TAG_W-1:0]  mem_req_tag;
    logic                    mem_resp_valid;
    logic                    mem_resp_ready;
    logic [`GLAY_TAG_W-1:0]  mem_resp_tag;
    logic [`GLAY_DATA_W-1:0] mem_resp_data;
    logic                    fifo_setup;
    logic                    done;

    // Base, lines, ready mask, checksum per test
    logic [31:0] stim [4*NUM_TESTS];

    // Current test as set by the main sequence
    logic [31:0] cur_base;
    logic [31:0] cur_lines;
    logic [31:0] cur_mask;
    int          req_start;
    int          wd_cycles = 0;

    // Responder state
    int                      total_reqs;
    logic [4:0]              mask_bit;
    logic [31:0]             lfsr;
    logic [`GLAY_TAG_W-1:0]  resp_tag_q [$];
    logic [`GLAY_DATA_W-1:0] resp_data_q [$];

    always #50 ap_clk = ~ap_clk;

    glay_setup_top u_glay_setup_top (
        .ap_clk         (ap_clk),
        .setup_areset   (setup_areset),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_req_tag    (mem_req_tag),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_ready (mem_resp_ready),
        .mem_resp_tag   (mem_resp_tag),
        .mem_resp_data  (mem_resp_data),
        .fifo_setup     (fifo_setup),
        .done           (done)
    );

    // --------------------
    // Helpers
    // --------------------
    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Setup phase, access phase, sample mid-cycle, idle
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge ap_clk);
        #5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge ap_clk);
        #5;
        penable = 1'b1;
        @(negedge ap_clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge ap_clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
        check_eq("pslverr on register write", 32'(err), 32'd0);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp,
                            input string what);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_eq("pslverr on register read", 32'(err), 32'd0);
        check_eq(what, rdata, exp);
    endtask

    // --------------------
    // Memory responder
    // --------------------
    // Samples at the falling edge and drives 5 ns after the rising edge
    initial begin : mem_responder
        logic req_fire;
        logic resp_fire;
        int   idx;
        total_reqs     = 0;
        mask_bit       = 5'd0;
        lfsr           = 32'hb10b_e86d;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_tag   = '0;
        mem_resp_data  = '0;
        forever begin
            @(negedge ap_clk);
            req_fire  = mem_req_valid & mem_req_ready;
            resp_fire = mem_resp_valid & mem_resp_ready;
            if (resp_fire) begin
                void'(resp_tag_q.pop_front());
                void'(resp_data_q.pop_front());
            end
            if (req_fire) begin
                idx = total_reqs - req_start;
                check_eq("request inside line count", 32'(32'(idx) < cur_lines), 32'd1);
                check_eq("request address", mem_req_addr,
                         cur_base + 32'(idx) * `GLAY_LINE_BYTES);
                check_eq("request tag", 32'(mem_req_tag), 32'(idx % 256));
                // Answer in order with data keyed to the address
                resp_tag_q.push_back(mem_req_tag);
                resp_data_q.push_back(mem_req_addr ^ 32'h5a5a_0000);
                total_reqs = total_reqs + 1;
            end
            @(posedge ap_clk);
            #5;
            // Ready from the mask bit or else a random bit
            mask_bit = mask_bit + 5'd1;
            if (cur_mask[mask_bit]) begin
                mem_req_ready = 1'b1;
            end else begin
                lfsr          = lfsr_next(lfsr);
                mem_req_ready = lfsr[0];
            end
            mem_resp_valid = (resp_tag_q.size() != 0);
            if (resp_tag_q.size() != 0) begin
                mem_resp_tag  = resp_tag_q[0];
                mem_resp_data = resp_data_q[0];
            end
        end
    end

    // Watchdog limit known once the stim file is loaded
    initial begin : watchdog
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge ap_clk);
        $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main_seq
        logic [31:0] rdata;
        logic        err;
        logic [31:0] model_sum;
        int          wait_cnt;
        int          wd_total;
        setup_areset = 1'b1;
        paddr        = 8'h0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = 32'h0;
        cur_base     = 32'h0;
        cur_lines    = 32'h0;
        cur_mask     = 32'h0;
        req_start    = 0;
        $readmemh("sim/glay_setup_stim.txt", stim);
        wd_total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            wd_total = wd_total + int'(stim[4*t+1]) * 40 + 200;
        end
        wd_cycles = wd_total;

        repeat (3) @(posedge ap_clk);
        #5;
        setup_areset = 1'b0;

        // Start refused inside the FIFO setup window
        @(negedge ap_clk);
        check_eq("fifo_setup after reset", 32'(fifo_setup), 32'd1);
        check_eq("done after reset", 32'(done), 32'd0);
        check_eq("mem_req_valid after reset", 32'(mem_req_valid), 32'd0);
        apb_access(1'b1, `GLAY_REG_CTRL, 32'h1, rdata, err);
        check_eq("start during fifo setup refused", 32'(err), 32'd1);
        // The access above spans three rising edges
        wait_cnt = 3;
        @(negedge ap_clk);
        while (fifo_setup === 1'b1) begin
            @(negedge ap_clk);
            wait_cnt = wait_cnt + 1;
        end
        check_eq("fifo_setup fall in time",
                 32'(wait_cnt <= `GLAY_FIFO_SETUP_CYCLES + 2), 32'd1);
        repeat (4) @(negedge ap_clk);
        check_eq("requests after refused start", 32'(total_reqs), 32'd0);
        read_reg(`GLAY_REG_STATUS, 32'h0, "status after refused start");

        // Register readback and unmapped addresses
        write_reg(`GLAY_REG_BASE, 32'h1234_5640);
        read_reg(`GLAY_REG_BASE, 32'h1234_5640, "base readback");
        write_reg(`GLAY_REG_LINES, 32'h0000_0abc);
        read_reg(`GLAY_REG_LINES, 32'h0000_0abc, "lines readback");
        apb_access(1'b0, 8'h14, 32'h0, rdata, err);
        check_eq("unmapped read pslverr", 32'(err), 32'd1);
        apb_access(1'b1, 8'h20, 32'h1, rdata, err);
        check_eq("unmapped write pslverr", 32'(err), 32'd1);

        // --------------------
        // Descriptor tests
        // --------------------
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_base  = stim[4*t];
            cur_lines = stim[4*t+1];
            cur_mask  = stim[4*t+2];
            // Sum of address XOR pattern over all lines
            model_sum = 32'h0;
            for (int i = 0; i < int'(cur_lines); i++) begin
                model_sum = model_sum +
                            ((cur_base + 32'(i) * `GLAY_LINE_BYTES) ^ 32'h5a5a_0000);
            end
            check_eq("stim file checksum", stim[4*t+3], model_sum);
            req_start = total_reqs;
            write_reg(`GLAY_REG_BASE, cur_base);
            write_reg(`GLAY_REG_LINES, cur_lines);
            write_reg(`GLAY_REG_CTRL, 32'h1);
            // Second start lands while the kernel is busy
            apb_access(1'b1, `GLAY_REG_CTRL, 32'h1, rdata, err);
            check_eq("start while busy refused", 32'(err), 32'd1);
            while (done !== 1'b1) begin
                @(negedge ap_clk);
            end
            read_reg(`GLAY_REG_STATUS, (cur_lines << 16) | 32'h2, "status after done");
            read_reg(`GLAY_REG_SUM, model_sum, "checksum");
            check_eq("requests issued", 32'(total_reqs - req_start), cur_lines);
            check_eq("responses outstanding", 32'(resp_tag_q.size()), 32'd0);
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/glay_setup_pkg.sv
hdl/glay_sync_fifo.sv
hdl/glay_serial_read_engine.sv
hdl/glay_kernel_setup.sv
hdl/glay_apb_descriptor.sv
hdl/glay_setup_top.sv
sim/glay_setup_asserts.sv
sim/glay_setup_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the setup stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f project.f --top-module glay_setup_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vglay_setup_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

/* sim/glay_setup_stim.txt */
// One graph descriptor test per line, all words hex
// base     lines    ready_mask expected_checksum
00001000 00000004 00000000 69684180
00002000 00000001 ffffffff 5a5a2000
00000000 00000000 00000000 00000000
00000400 00000014 0000ffff 0f087f80
00008000 0000012c aaaaaaaa e239cc80
00000040 00000009 ffffffff 2d2a0b40
